// File: hw/power_consts.svh
`ifndef POWER_CONSTS_SVH
`define POWER_CONSTS_SVH

// Deglitch depth in equal samples
`define FILTER_DEPTH 8

// All switches off before a new bridge pattern
`define DEAD_CYCLES 50

// Free-running PWM counter for the charge switch
`define PWM_WIDTH 19

// Soft-start duty ramp
`define RAMP_STEPS 15
`define STEP_CYCLES_DEFAULT 100000000

// LED half-periods at 50 MHz
`define LED_SLOW 50000000
`define LED_FAST 6250000

`endif

// File: hw/cmd_pkg.sv
package cmd_pkg;

  typedef enum logic [7:0] {
    CMD_PAUSE         = 8'd0,  // Also the confirm code
    CMD_PLUS          = 8'd1,
    CMD_MINUS         = 8'd2,
    CMD_BALLAST_P     = 8'd3,
    CMD_BALLAST_N     = 8'd4,
    CMD_START_ARM     = 8'd5,
    CMD_SHUTDOWN      = 8'd6,
    CMD_DISCHARGE_ARM = 8'd7
  } cmd_code_t;

  typedef enum logic [2:0] {
    IDLE,
    START_WAIT,
    DIS_0,
    DIS_1,
    DIS_2,
    ERROR
  } dec_state_t;

  typedef struct packed {
    logic      stb;   // High while the host pulse is on
    cmd_code_t code;
  } cmd_lines_t;

endpackage

// File: hw/power_pkg.sv
`include "power_consts.svh"

package power_pkg;

  localparam int RAMP_STEP_W = $clog2(`RAMP_STEPS + 2);

  typedef struct packed {
    logic [3:0] top;
    logic [3:0] bot;
    logic       plus;
    logic       minus;
    logic       pause_p;
    logic       pause_n;
  } bridge_pat_t;

  typedef struct packed {
    logic [3:0] err_dr;  // Gate driver errors
    logic       err_u;
    logic       err_i;
    logic       bt;      // Over-temperature
    logic       stop_k;
  } fault_t;

  // Compare value for the charge PWM per ramp step
  function automatic logic [`PWM_WIDTH-1:0] ramp_duty(input logic [RAMP_STEP_W-1:0] step);
    case (step)
      0:             ramp_duty = '0;
      1, 2, 3, 4:    ramp_duty = {2'b01, {(`PWM_WIDTH - 2){1'b0}}};
      5, 6, 7, 8:    ramp_duty = {2'b10, {(`PWM_WIDTH - 2){1'b0}}};
      9, 10, 11:     ramp_duty = {2'b11, {(`PWM_WIDTH - 2){1'b0}}};
      default:       ramp_duty = '1;  // Switch held on
    endcase
  endfunction

endpackage

// File: hw/ctrl_if.sv
`timescale 1ns/1ps

interface bridge_if;
  import power_pkg::*;

  logic        req;
  logic        clr;
  bridge_pat_t pat;
  logic        busy;

  modport decoder (
    output req,
    output clr,
    output pat,
    input  busy
  );

  modport sequencer (
    input  req,
    input  clr,
    input  pat,
    output busy
  );
endinterface

interface charge_if;
  logic start;
  logic stop;
  logic active;
  logic done;

  modport decoder (
    output start,
    output stop,
    input  active,
    input  done
  );

  modport softstart (
    input  start,
    input  stop,
    output active,
    output done
  );
endinterface

// File: hw/input_filter.sv
`timescale 1ns/1ps
`include "power_consts.svh"

module input_filter #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  payload_t i_d,
  output payload_t o_q
);

  localparam int CNT_W = $clog2(`FILTER_DEPTH + 1);

  payload_t         last;
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      last <= '0;
      cnt  <= '0;
      o_q  <= '0;
    end else begin
      last <= i_d;
      if (i_d != last) begin
        cnt <= '0;  // Any change restarts the window
      end else if (cnt != CNT_W'(`FILTER_DEPTH)) begin
        cnt <= cnt + 1'b1;
      end
      if (cnt == CNT_W'(`FILTER_DEPTH)) begin
        o_q <= last;
      end
    end
  end

endmodule

// File: hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                clk,
  input  logic                rstn,
  input  cmd_pkg::cmd_lines_t i_lines,
  input  logic                i_lock,
  bridge_if.decoder           bridge,
  charge_if.decoder           charge
);

  import cmd_pkg::*;
  import power_pkg::*;

  dec_state_t  state;
  logic        stb_d;
  logic        fall;
  logic        busy;
  logic        device_ready;
  bridge_pat_t pat_sel;

  assign fall = stb_d & ~i_lines.stb;
  assign busy = bridge.busy | charge.active;

  always_comb begin
    pat_sel = '0;
    case (i_lines.code)
      CMD_PLUS: begin
        pat_sel.top  = 4'b0001;
        pat_sel.bot  = 4'b0010;
        pat_sel.plus = 1'b1;
      end
      CMD_MINUS: begin
        pat_sel.top   = 4'b0010;
        pat_sel.bot   = 4'b0001;
        pat_sel.minus = 1'b1;
      end
      CMD_BALLAST_P: begin
        pat_sel.top     = 4'b0100;
        pat_sel.bot     = 4'b1000;
        pat_sel.pause_p = 1'b1;
      end
      CMD_BALLAST_N: begin
        pat_sel.top     = 4'b1000;
        pat_sel.bot     = 4'b0100;
        pat_sel.pause_n = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fall) begin
      bridge.pat <= pat_sel;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= IDLE;
      stb_d        <= 1'b0;
      device_ready <= 1'b0;
      bridge.req   <= 1'b0;
      bridge.clr   <= 1'b0;
      charge.start <= 1'b0;
      charge.stop  <= 1'b0;
    end else begin
      stb_d        <= i_lines.stb;
      bridge.req   <= 1'b0;
      bridge.clr   <= 1'b0;
      charge.start <= 1'b0;
      charge.stop  <= 1'b0;
      if (charge.done) begin
        device_ready <= 1'b1;  // Ramp finished
      end
      if (i_lock) begin
        state        <= ERROR;
        device_ready <= 1'b0;
      end else if (fall && i_lines.code == CMD_SHUTDOWN) begin
        charge.stop  <= 1'b1;  // Obeyed in any state
        bridge.clr   <= 1'b1;
        device_ready <= 1'b0;
        state        <= IDLE;
      end else if (fall) begin
        case (state)
          IDLE: begin
            if (!busy) begin
              case (i_lines.code)
                CMD_PAUSE:         bridge.clr <= 1'b1;
                CMD_PLUS, CMD_MINUS, CMD_BALLAST_P, CMD_BALLAST_N:
                                   bridge.req <= device_ready;
                CMD_START_ARM:     state <= START_WAIT;
                CMD_DISCHARGE_ARM: state <= DIS_0;
                default: ;
              endcase
            end
          end
          START_WAIT: begin
            if (i_lines.code == CMD_PAUSE) begin
              charge.start <= 1'b1;
              bridge.clr   <= 1'b1;  // Bridge off while charging
            end
            state <= IDLE;
          end
          DIS_0: state <= (i_lines.code == CMD_PAUSE) ? DIS_1 : IDLE;
          DIS_1: state <= (i_lines.code == CMD_DISCHARGE_ARM) ? DIS_2 : IDLE;
          DIS_2: begin
            if (i_lines.code == CMD_PAUSE) begin
              device_ready <= 1'b1;
            end
            state <= IDLE;
          end
          default: ;  // ERROR held until reset
        endcase
      end
    end
  end

endmodule

// File: hw/bridge_sequencer.sv
`timescale 1ns/1ps
`include "power_consts.svh"

module bridge_sequencer (
  input  logic                   clk,
  input  logic                   rstn,
  bridge_if.sequencer            sig,
  input  logic                   i_lock,
  output power_pkg::bridge_pat_t o_pat
);

  import power_pkg::*;

  localparam int DEAD_W = $clog2(`DEAD_CYCLES + 1);

  bridge_pat_t       pending;
  logic              pend;
  logic [DEAD_W-1:0] dead_cnt;

  assign sig.busy = pend | sig.req;

  always_ff @(posedge clk) begin
    if (sig.req) begin
      pending <= sig.pat;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_pat    <= '0;
      pend     <= 1'b0;
      dead_cnt <= '0;
    end else if (i_lock || sig.clr) begin
      o_pat    <= '0;  // Also drops a pending pattern
      pend     <= 1'b0;
      dead_cnt <= '0;
    end else if (sig.req) begin
      o_pat    <= '0;
      pend     <= 1'b1;
      dead_cnt <= DEAD_W'(`DEAD_CYCLES);
    end else if (pend) begin
      if (dead_cnt == '0) begin
        o_pat <= pending;
        pend  <= 1'b0;
      end else begin
        dead_cnt <= dead_cnt - 1'b1;
      end
    end
  end

endmodule

// File: hw/softstart.sv
`timescale 1ns/1ps
`include "power_consts.svh"

module softstart #(
  parameter int step_cycles = `STEP_CYCLES_DEFAULT
) (
  input  logic       clk,
  input  logic       rstn,
  charge_if.softstart sig,
  input  logic       i_lock,
  output logic       o_charge_en,
  output logic       o_charge_pwm,
  output logic       o_start,
  output logic       o_fan
);

  import power_pkg::*;

  localparam int TMR_W = $clog2(step_cycles + 1);

  logic [RAMP_STEP_W-1:0] step;
  logic [TMR_W-1:0]       timer;
  logic [`PWM_WIDTH-1:0]  pwm_cnt;
  logic [`PWM_WIDTH-1:0]  duty;

  assign sig.active   = (step != '0);
  assign duty         = ramp_duty(step);
  assign o_charge_pwm = o_charge_en & ((pwm_cnt < duty) | (&duty));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      step        <= '0;
      timer       <= '0;
      o_charge_en <= 1'b0;
      o_start     <= 1'b0;
      o_fan       <= 1'b0;
      sig.done    <= 1'b0;
    end else begin
      sig.done <= 1'b0;
      if (i_lock || sig.stop) begin
        step        <= '0;
        timer       <= '0;
        o_charge_en <= 1'b0;
        o_start     <= 1'b0;
        o_fan       <= i_lock;  // Fan keeps cooling on a fault
      end else if (sig.start) begin
        step        <= RAMP_STEP_W'(1);
        timer       <= TMR_W'(step_cycles - 1);
        o_charge_en <= 1'b1;
        o_start     <= 1'b0;
        o_fan       <= 1'b1;
      end else if (sig.active) begin
        if (timer == '0) begin
          timer <= TMR_W'(step_cycles - 1);
          if (step == RAMP_STEP_W'(`RAMP_STEPS + 1)) begin
            step        <= '0;  // Hold step over, charge switch off
            o_charge_en <= 1'b0;
            sig.done    <= 1'b1;
          end else begin
            if (step == RAMP_STEP_W'(`RAMP_STEPS)) begin
              o_start <= 1'b1;
            end
            step <= step + 1'b1;
          end
        end else begin
          timer <= timer - 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/fault_monitor.sv
`timescale 1ns/1ps
`include "power_consts.svh"

module fault_monitor (
  input  logic              clk,
  input  logic              rstn,
  input  power_pkg::fault_t i_fault,
  output logic              o_lock,
  output power_pkg::fault_t o_ind,
  output logic              o_break,
  output logic              o_led
);

  import power_pkg::*;

  localparam int LED_W = $clog2(`LED_SLOW);

  logic [LED_W-1:0] led_cnt;

  assign o_break = o_lock;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_lock <= 1'b0;
      o_ind  <= '0;
    end else begin
      o_lock <= o_lock | (|i_fault);  // Sticky until reset
      o_ind  <= o_ind | i_fault;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      led_cnt <= LED_W'(`LED_SLOW - 1);  // Full dark half-period first
      o_led   <= 1'b0;
    end else if (led_cnt == '0) begin
      o_led   <= ~o_led;
      led_cnt <= o_lock ? LED_W'(`LED_FAST - 1) : LED_W'(`LED_SLOW - 1);
    end else begin
      led_cnt <= led_cnt - 1'b1;
    end
  end

endmodule

// File: hw/power_ctrl_top.sv
`timescale 1ns/1ps
`include "power_consts.svh"

module power_ctrl_top #(
  parameter int step_cycles = `STEP_CYCLES_DEFAULT
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       i_cmd_stb_n,
  input  logic [2:0] i_cmd_n,
  input  logic [3:0] i_err_dr_n,
  input  logic       i_err_u_n,
  input  logic       i_err_i_n,
  input  logic       i_bt,
  input  logic       i_stop_k_n,
  output logic [3:0] o_top,
  output logic [3:0] o_bot,
  output logic       o_plus,
  output logic       o_minus,
  output logic       o_pause_p,
  output logic       o_pause_n,
  output logic       o_charge,
  output logic       o_ch,
  output logic       o_start,
  output logic       o_st,
  output logic       o_fan,
  output logic       o_break,
  output logic [3:0] o_erbd,
  output logic       o_avv,
  output logic       o_avi,
  output logic       o_td,
  output logic       o_stop,
  output logic       o_led_ready
);

  import cmd_pkg::*;
  import power_pkg::*;

  cmd_lines_t  cmd_raw;
  cmd_lines_t  cmd_flt;
  fault_t      fault_raw;
  fault_t      fault_flt;
  fault_t      ind;
  bridge_pat_t pat;
  logic        lock;
  logic        start;

  bridge_if bridge ();
  charge_if charge ();

  // Pins are active low except the temperature input
  assign cmd_raw   = {~i_cmd_stb_n, 5'b0, ~i_cmd_n};
  assign fault_raw = {~i_err_dr_n, ~i_err_u_n, ~i_err_i_n, i_bt, ~i_stop_k_n};

  input_filter #(.payload_t(cmd_lines_t)) u_cmd_filter (
    .clk  (clk),
    .rstn (rstn),
    .i_d  (cmd_raw),
    .o_q  (cmd_flt)
  );

  input_filter #(.payload_t(fault_t)) u_fault_filter (
    .clk  (clk),
    .rstn (rstn),
    .i_d  (fault_raw),
    .o_q  (fault_flt)
  );

  cmd_decoder u_decoder (
    .clk     (clk),
    .rstn    (rstn),
    .i_lines (cmd_flt),
    .i_lock  (lock),
    .bridge  (bridge.decoder),
    .charge  (charge.decoder)
  );

  bridge_sequencer u_sequencer (
    .clk    (clk),
    .rstn   (rstn),
    .sig    (bridge.sequencer),
    .i_lock (lock),
    .o_pat  (pat)
  );

  softstart #(.step_cycles(step_cycles)) u_softstart (
    .clk          (clk),
    .rstn         (rstn),
    .sig          (charge.softstart),
    .i_lock       (lock),
    .o_charge_en  (o_charge),
    .o_charge_pwm (o_ch),
    .o_start      (start),
    .o_fan        (o_fan)
  );

  fault_monitor u_fault_monitor (
    .clk     (clk),
    .rstn    (rstn),
    .i_fault (fault_flt),
    .o_lock  (lock),
    .o_ind   (ind),
    .o_break (o_break),
    .o_led   (o_led_ready)
  );

  assign o_top     = pat.top;
  assign o_bot     = pat.bot;
  assign o_plus    = pat.plus;
  assign o_minus   = pat.minus;
  assign o_pause_p = pat.pause_p;
  assign o_pause_n = pat.pause_n;
  assign o_start   = start;
  assign o_st      = start;  // Second pin of the same signal
  assign o_erbd    = ind.err_dr;
  assign o_avv     = ind.err_u;
  assign o_avi     = ind.err_i;
  assign o_td      = ind.bt;
  assign o_stop    = ind.stop_k;

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 10
) (
  input  logic i_reset_req,
  output logic o_clk,
  output logic o_rstn
);

  initial begin
    o_clk = 1'b0;
    forever #(period_ns / 2) o_clk = ~o_clk;
  end

  // Reset at time zero, and again on each request
  initial begin
    o_rstn = 1'b0;
    forever begin
      repeat (reset_cycles) @(posedge o_clk);
      @(negedge o_clk);
      o_rstn = 1'b1;
      @(posedge i_reset_req);
      @(negedge o_clk);
      o_rstn = 1'b0;
    end
  end

endmodule

// File: verif/tb_power_ctrl.sv
`timescale 1ns/1ps
`include "power_consts.svh"

module tb_power_ctrl;

  import cmd_pkg::*;
  import power_pkg::*;

  localparam int CLK_PERIOD_NS   = 20;
  localparam int STEP_CYCLES     = 200;
  localparam int RAMP_CYCLES     = (`RAMP_STEPS + 1) * STEP_CYCLES;
  localparam int SETTLE          = `FILTER_DEPTH + 4;
  localparam int DECODE_BOUND    = `FILTER_DEPTH + 8;
  localparam int QUIET_CYCLES    = DECODE_BOUND + `DEAD_CYCLES + 8;
  localparam int CMD_CYCLES      = 150;
  localparam int WATCHDOG_CYCLES = 2 * RAMP_CYCLES + 3 * STEP_CYCLES + 80 * CMD_CYCLES + 1000;

  logic       clk;
  logic       rstn;
  logic       reset_req;
  logic       cmd_stb_n;
  logic [2:0] cmd_n;
  logic [3:0] err_dr_n;
  logic       err_u_n;
  logic       err_i_n;
  logic       bt;
  logic       stop_k_n;
  logic [3:0] sw_top;
  logic [3:0] sw_bot;
  logic       plus;
  logic       minus;
  logic       pause_p;
  logic       pause_n;
  logic       charge;
  logic       ch;
  logic       start;
  logic       st;
  logic       fan;
  logic       break_out;
  logic [3:0] erbd;
  logic       avv;
  logic       avi;
  logic       td;
  logic       stop_ind;
  logic       led_ready;

  integer seed;
  int     value_errs;
  int     other_errs;

  tb_clkgen #(.period_ns(CLK_PERIOD_NS), .reset_cycles(10)) u_clkgen (
    .i_reset_req (reset_req),
    .o_clk       (clk),
    .o_rstn      (rstn)
  );

  power_ctrl_top #(.step_cycles(STEP_CYCLES)) u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .i_cmd_stb_n (cmd_stb_n),
    .i_cmd_n     (cmd_n),
    .i_err_dr_n  (err_dr_n),
    .i_err_u_n   (err_u_n),
    .i_err_i_n   (err_i_n),
    .i_bt        (bt),
    .i_stop_k_n  (stop_k_n),
    .o_top       (sw_top),
    .o_bot       (sw_bot),
    .o_plus      (plus),
    .o_minus     (minus),
    .o_pause_p   (pause_p),
    .o_pause_n   (pause_n),
    .o_charge    (charge),
    .o_ch        (ch),
    .o_start     (start),
    .o_st        (st),
    .o_fan       (fan),
    .o_break     (break_out),
    .o_erbd      (erbd),
    .o_avv       (avv),
    .o_avi       (avi),
    .o_td        (td),
    .o_stop      (stop_ind),
    .o_led_ready (led_ready)
  );

  // Bridge pattern for each switching command
  function automatic bridge_pat_t expected_pat(input cmd_code_t code);
    bridge_pat_t p;
    p = '0;
    case (code)
      CMD_PLUS:      p = {4'b0001, 4'b0010, 4'b1000};
      CMD_MINUS:     p = {4'b0010, 4'b0001, 4'b0100};
      CMD_BALLAST_P: p = {4'b0100, 4'b1000, 4'b0010};
      CMD_BALLAST_N: p = {4'b1000, 4'b0100, 4'b0001};
      default:       p = '0;
    endcase
    return p;
  endfunction

  function automatic bridge_pat_t read_bridge();
    return {sw_top, sw_bot, plus, minus, pause_p, pause_n};
  endfunction

  function automatic fault_t read_ind();
    return {erbd, avv, avi, td, stop_ind};
  endfunction

  function automatic logic read_out(input string name);
    if (name == "o_charge") return charge;
    else if (name == "o_start") return start;
    else if (name == "o_fan") return fan;
    else if (name == "o_break") return break_out;
    return 1'bx;
  endfunction

  task automatic check_pat(input string name, input bridge_pat_t exp, input bridge_pat_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_fault(input string name, input fault_t exp, input fault_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_delay(input string name, input int exp, input int act);
    if (act < exp - 1 || act > exp + 1) begin
      $display("%s took %0d cycles instead of %0d, seen at %0t ns", name, act, exp, $time);
      other_errs++;
    end
  endtask

  task automatic drive_faults(input fault_t f);
    err_dr_n = ~f.err_dr;
    err_u_n  = ~f.err_u;
    err_i_n  = ~f.err_i;
    bt       = f.bt;  // Only active-high pin
    stop_k_n = ~f.stop_k;
  endtask

  task automatic drive_idle();
    cmd_stb_n = 1'b1;
    cmd_n     = 3'b111;
    drive_faults('0);
  endtask

  task automatic do_reset();
    @(negedge clk);
    drive_idle();
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    @(posedge rstn);
  endtask

  // Code held before, during and after the strobe pulse
  task automatic send_cmd(input cmd_code_t code);
    int gap;
    gap = SETTLE + ($unsigned($random(seed)) % 8);
    repeat (gap) @(negedge clk);
    cmd_n = ~code[2:0];
    repeat (SETTLE) @(negedge clk);
    cmd_stb_n = 1'b0;
    repeat (SETTLE) @(negedge clk);
    cmd_stb_n = 1'b1;
  endtask

  task automatic wait_bit(input string name, input logic want, input int limit, output int n);
    n = 0;
    while (read_out(name) !== want && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (read_out(name) !== want) begin
      $display("%s did not go to %b within %0d cycles, at %0t ns", name, want, limit, $time);
      other_errs++;
    end
  endtask

  task automatic wait_clear(input string name);
    int n;
    n = 0;
    while (read_bridge() !== '0 && n < DECODE_BOUND) begin
      @(negedge clk);
      n++;
    end
    check_pat(name, '0, read_bridge());
  endtask

  task automatic expect_switch(input bridge_pat_t want, input logic prev_on);
    int zeros;
    wait_clear("bridge before new pattern");
    zeros = 0;
    while (read_bridge() === '0 && zeros < DECODE_BOUND + `DEAD_CYCLES + 4) begin
      @(negedge clk);
      zeros++;
    end
    check_pat("bridge", want, read_bridge());
    if (prev_on) begin
      check_delay("Dead time", `DEAD_CYCLES + 1, zeros);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (read_bridge() !== '0) begin
        check_pat("bridge after ignored command", '0, read_bridge());
        break;
      end
    end
  endtask

  task automatic check_outputs_low();
    check_pat("bridge", '0, read_bridge());
    check_bit("o_charge", 1'b0, charge);
    check_bit("o_ch", 1'b0, ch);
    check_bit("o_start", 1'b0, start);
    check_bit("o_st", 1'b0, st);
    check_bit("o_fan", 1'b0, fan);
    check_bit("o_break", 1'b0, break_out);
    check_bit("o_led_ready", 1'b0, led_ready);
    check_fault("fault indicators", '0, read_ind());
  endtask

  task automatic confirm_discharge();
    send_cmd(CMD_DISCHARGE_ARM);
    send_cmd(CMD_PAUSE);
    send_cmd(CMD_DISCHARGE_ARM);
    send_cmd(CMD_PAUSE);
  endtask

  // Comparing process for the rules that hold in every cycle
  always @(negedge clk) begin
    if (rstn) begin
      check_bit("o_led_ready", 1'b0, led_ready);  // Slow half-period outlasts the run
      if (st !== start) begin
        $display("o_st and o_start disagree at %0t ns", $time);
        other_errs++;
      end
      if (ch === 1'b1 && charge !== 1'b1) begin
        $display("o_ch is on without o_charge at %0t ns", $time);
        other_errs++;
      end
      if (read_bridge() !== '0 && read_bridge() !== expected_pat(CMD_PLUS) &&
          read_bridge() !== expected_pat(CMD_MINUS) &&
          read_bridge() !== expected_pat(CMD_BALLAST_P) &&
          read_bridge() !== expected_pat(CMD_BALLAST_N)) begin
        check_pat("bridge legal pattern", '0, read_bridge());
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    cmd_code_t code;
    fault_t    flt;
    logic      prev_on;
    int        n;
    int        pick;
    seed       = 32'h93b7_228c;
    value_errs = 0;
    other_errs = 0;
    reset_req  = 1'b0;
    drive_idle();

    // Reset state and the not-ready guard
    @(posedge rstn);
    check_outputs_low();
    send_cmd(CMD_PLUS);
    expect_quiet(QUIET_CYCLES);

    // Broken discharge confirm, then the full one
    send_cmd(CMD_DISCHARGE_ARM);
    send_cmd(CMD_PLUS);
    expect_quiet(QUIET_CYCLES);
    send_cmd(CMD_PLUS);
    expect_quiet(QUIET_CYCLES);
    do_reset();
    confirm_discharge();
    send_cmd(CMD_PLUS);
    expect_switch(expected_pat(CMD_PLUS), 1'b0);
    send_cmd(CMD_PAUSE);
    wait_clear("bridge after PAUSE");

    // Soft start
    do_reset();
    send_cmd(CMD_START_ARM);
    send_cmd(CMD_PAUSE);
    wait_bit("o_charge", 1'b1, DECODE_BOUND, n);
    check_bit("o_fan", 1'b1, fan);
    check_bit("o_ch", 1'b1, ch);  // PWM counter still below quarter scale
    wait_bit("o_start", 1'b1, RAMP_CYCLES, n);
    check_delay("Ramp to o_start", `RAMP_STEPS * STEP_CYCLES, n);
    check_bit("o_st", 1'b1, st);
    check_bit("o_charge", 1'b1, charge);
    wait_bit("o_charge", 1'b0, STEP_CYCLES + 4, n);
    check_delay("Hold step", STEP_CYCLES, n);
    check_bit("o_ch", 1'b0, ch);
    check_bit("o_fan", 1'b1, fan);

    // Bridge commands in random order
    prev_on = 1'b0;
    for (int i = 0; i < 12; i++) begin
      pick = 1 + ($unsigned($random(seed)) % 4);
      code = cmd_code_t'(pick);
      send_cmd(code);
      expect_switch(expected_pat(code), prev_on);
      prev_on = 1'b1;
      if (i % 4 == 3) begin
        send_cmd(CMD_PAUSE);
        wait_clear("bridge after PAUSE");
        prev_on = 1'b0;
      end
    end

    // Shutdown with the bridge on
    send_cmd(CMD_PLUS);
    expect_switch(expected_pat(CMD_PLUS), 1'b0);
    send_cmd(CMD_SHUTDOWN);
    wait_clear("bridge after SHUTDOWN");
    check_bit("o_start", 1'b0, start);
    check_bit("o_charge", 1'b0, charge);
    check_bit("o_fan", 1'b0, fan);
    send_cmd(CMD_PLUS);
    expect_quiet(QUIET_CYCLES);

    // Shutdown during a ramp
    send_cmd(CMD_START_ARM);
    send_cmd(CMD_PAUSE);
    wait_bit("o_charge", 1'b1, DECODE_BOUND, n);
    repeat (3 * STEP_CYCLES) @(negedge clk);
    check_bit("o_charge", 1'b1, charge);
    send_cmd(CMD_SHUTDOWN);
    wait_bit("o_charge", 1'b0, DECODE_BOUND, n);
    check_bit("o_fan", 1'b0, fan);
    check_bit("o_start", 1'b0, start);
    send_cmd(CMD_PLUS);
    expect_quiet(QUIET_CYCLES);

    // Fault lock on one random pin
    do_reset();
    confirm_discharge();
    send_cmd(CMD_PLUS);
    expect_switch(expected_pat(CMD_PLUS), 1'b0);
    pick = $unsigned($random(seed)) % 8;
    flt  = fault_t'(8'd1 << pick);
    @(negedge clk);
    drive_faults(flt);
    wait_bit("o_break", 1'b1, DECODE_BOUND, n);
    drive_faults('0);
    wait_clear("bridge under fault lock");
    check_bit("o_fan", 1'b1, fan);
    check_fault("fault indicators", flt, read_ind());
    send_cmd(CMD_PLUS);
    expect_quiet(QUIET_CYCLES);
    send_cmd(CMD_START_ARM);
    send_cmd(CMD_PAUSE);
    expect_quiet(QUIET_CYCLES);
    check_bit("o_charge", 1'b0, charge);
    check_bit("o_break", 1'b1, break_out);
    check_fault("fault indicators", flt, read_ind());
    do_reset();
    check_outputs_low();

    $display("Error count: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+hw
hw/cmd_pkg.sv
hw/power_pkg.sv
hw/ctrl_if.sv
hw/input_filter.sv
hw/cmd_decoder.sv
hw/bridge_sequencer.sv
hw/softstart.sv
hw/fault_monitor.sv
hw/power_ctrl_top.sv
verif/tb_clkgen.sv
verif/tb_power_ctrl.sv

// File: Bender.yml
package:
  name: power_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/cmd_pkg.sv
      - hw/power_pkg.sv
      - hw/ctrl_if.sv
      - hw/input_filter.sv
      - hw/cmd_decoder.sv
      - hw/bridge_sequencer.sv
      - hw/softstart.sv
      - hw/fault_monitor.sv
      - hw/power_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_clkgen.sv
      - verif/tb_power_ctrl.sv
